// File: viterbi_dec.f
source/viterbi_pkg.sv
source/branch_metric.sv
source/add_compare_select.sv
source/survivor_memory.sv
source/traceback.sv
source/viterbi_dec.sv
test/viterbi_tb.sv

// File: run_sim.sh
#!/bin/sh
# build with verilator and run, pass only if the testbench prints its pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module viterbi_tb \
  -f viterbi_dec.f -Mdir obj_dir \
  && ./obj_dir/Vviterbi_tb | tee /dev/stderr | grep -F '*** PASSED ***' > /dev/null \
  && echo "run_sim: simulation passed" \
  || { echo "run_sim: simulation failed"; exit 1; }

// File: test/viterbi_tb.sv
`timescale 1ns/1ns
`default_nettype none

module viterbi_tb;

  localparam int max_frame = 64;
  // 4 x max_frame cycles per test, 10 tests, 10 ns clock
  localparam int watchdog_ns = 4 * max_frame * 10 * 10;
  localparam int wait_limit = 4 * max_frame + 16;

  logic clk;
  logic rst;
  logic [1:0] sym;
  logic sym_valid;
  logic sym_last;
  logic sym_ready;
  logic bit_out;
  logic bit_valid;
  logic bit_last;
  logic bit_ready;

  // message bits, encoded symbols, collected output
  logic msg [max_frame];
  logic [1:0] code [max_frame];
  logic got [max_frame];
  logic got_last [max_frame];
  int got_count;

  int err_count;
  int tests_run;
  int tests_passed;

  viterbi_dec #(
    .max_frame (max_frame)
  ) DUT (
    .clk       (clk),
    .rst       (rst),
    .sym       (sym),
    .sym_valid (sym_valid),
    .sym_last  (sym_last),
    .sym_ready (sym_ready),
    .bit_out   (bit_out),
    .bit_valid (bit_valid),
    .bit_last  (bit_last),
    .bit_ready (bit_ready)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    #(watchdog_ns);
    $display("watchdog expired at %0t ns, the decoder stopped responding", $time);
    $display("*** FAILED ***");
    $finish;
  end

  task automatic report_mismatch(input string what);
    $display("CHECK FAILED at %0t ns: %s", $time, what);
    err_count++;
  endtask

  task automatic report_problem(input string what);
    $display("ERROR at %0t ns: %s", $time, what);
    err_count++;
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests_run++;
    if (err_count == errs_before) begin
      tests_passed++;
      $display("test %s: pass", name);
    end else begin
      $display("test %s: fail, %0d errors", name, err_count - errs_before);
    end
  endtask

  // random message with two zero tail bits, encoded from state 0
  task automatic build_frame(input int len);
    logic [1:0] s;
    logic u;
    s = 2'b00;
    for (int i = 0; i < len; i++) begin
      msg[i] = (i < len - 2) ? 1'($urandom_range(1, 0)) : 1'b0;
      u = msg[i];
      // c0 from generator 7, c1 from generator 5
      code[i] = {u ^ s[1] ^ s[0], u ^ s[0]};
      // newest bit goes into the upper state bit
      s = {u, s[1]};
    end
  endtask

  task automatic send_frame(input int len);
    int idx;
    int waits;
    idx = 0;
    waits = 0;
    while (idx < len) begin
      @(negedge clk);
      sym = code[idx];
      sym_valid = 1'b1;
      sym_last = (idx == len - 1);
      // sym_ready is settled mid cycle, transfer lands on the next rising edge
      if (sym_ready) begin
        idx++;
      end else begin
        waits++;
        if (waits > wait_limit) begin
          report_problem("sym_ready never came back high while sending");
          break;
        end
      end
    end
  endtask

  task automatic collect_bits(input bit stall);
    int cycles;
    bit finished;
    bit held;
    logic held_bit;
    got_count = 0;
    cycles = 0;
    finished = 1'b0;
    held = 1'b0;
    held_bit = 1'b0;
    while (!finished) begin
      @(negedge clk);
      sym_valid = 1'b0;
      sym_last = 1'b0;
      bit_ready = stall ? 1'($urandom_range(1, 0)) : 1'b1;
      if (sym_ready) begin
        report_mismatch("sym_ready high before the last bit transferred");
      end
      // a stalled bit must stay valid and unchanged
      if (held && (!bit_valid || bit_out != held_bit)) begin
        report_mismatch($sformatf("output changed during stall at bit %0d", got_count));
      end
      held = bit_valid && !bit_ready;
      held_bit = bit_out;
      if (bit_valid && bit_ready) begin
        if (got_count < max_frame) begin
          got[got_count] = bit_out;
          got_last[got_count] = bit_last;
        end
        got_count++;
        if (bit_last || got_count > max_frame) begin
          finished = 1'b1;
        end
      end
      cycles++;
      if (!finished && cycles > wait_limit) begin
        report_problem("decoder never delivered a bit flagged as last");
        finished = 1'b1;
      end
    end
  endtask

  task automatic compare_frame(input int len);
    int n;
    if (got_count != len) begin
      report_mismatch($sformatf("got %0d bits, expected %0d", got_count, len));
    end
    n = (got_count < len) ? got_count : len;
    for (int i = 0; i < n; i++) begin
      if (got[i] !== msg[i]) begin
        report_mismatch($sformatf("bit %0d is %0b, expected %0b", i, got[i], msg[i]));
      end
      if (got_last[i] !== (i == len - 1)) begin
        report_mismatch($sformatf("bit_last is %0b on bit %0d of %0d", got_last[i], i, len));
      end
    end
  endtask

  task automatic run_frame(input int len, input bit stall);
    send_frame(len);
    collect_bits(stall);
    compare_frame(len);
  endtask

  task automatic test_reset_state();
    int errs;
    errs = err_count;
    @(negedge clk);
    if (sym_ready !== 1'b1) begin
      report_mismatch("sym_ready not high after reset");
    end
    if (bit_valid !== 1'b0) begin
      report_mismatch("bit_valid not low after reset");
    end
    finish_test("reset_state", errs);
  endtask

  task automatic test_clean_frame();
    int errs;
    errs = err_count;
    build_frame(32);
    run_frame(32, 1'b0);
    finish_test("clean_frame_32", errs);
  endtask

  // single errors 8 symbols apart, well inside the free distance of 5
  task automatic test_spaced_errors();
    int errs;
    int idx;
    errs = err_count;
    build_frame(64);
    for (int k = 0; k < 8; k++) begin
      idx = 3 + 8 * k;
      code[idx][k % 2] = ~code[idx][k % 2];
    end
    run_frame(64, 1'b0);
    finish_test("spaced_errors_64", errs);
  endtask

  task automatic test_output_stalls();
    int errs;
    errs = err_count;
    build_frame(40);
    run_frame(40, 1'b1);
    finish_test("output_stalls_40", errs);
  endtask

  // no idle gap between frames, metrics must restart each time
  task automatic test_back_to_back();
    int errs;
    int lens [3];
    errs = err_count;
    lens = '{5, 17, 64};
    for (int f = 0; f < 3; f++) begin
      build_frame(lens[f]);
      run_frame(lens[f], 1'b0);
    end
    finish_test("back_to_back", errs);
  endtask

  initial begin
    void'($urandom(32'h581));
    err_count = 0;
    tests_run = 0;
    tests_passed = 0;
    rst = 1'b1;
    sym = 2'b00;
    sym_valid = 1'b0;
    sym_last = 1'b0;
    bit_ready = 1'b0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    test_reset_state();
    test_clean_frame();
    test_spaced_errors();
    test_output_stalls();
    test_back_to_back();

    $display("tests run %0d, passed %0d, failed %0d, check errors %0d",
             tests_run, tests_passed, tests_run - tests_passed, err_count);
    if (err_count == 0 && tests_passed == tests_run) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: source/viterbi_dec.sv
`timescale 1ns/1ns
`default_nettype none

module viterbi_dec
  import viterbi_pkg::*;
#(
  parameter int max_frame = 64
) (
  input  wire             clk,
  input  wire             rst,
  input  wire [sym_w-1:0] sym,
  input  wire             sym_valid,
  input  wire             sym_last,
  output logic            sym_ready,
  output logic            bit_out,
  output logic            bit_valid,
  output logic            bit_last,
  input  wire             bit_ready
);

  localparam int addr_w = $clog2(max_frame);
  localparam int len_w = $clog2(max_frame + 1);

  localparam logic [1:0] st_idle = 2'd0;
  localparam logic [1:0] st_recv = 2'd1;
  localparam logic [1:0] st_decode = 2'd2;

  logic [1:0] state_q;
  // symbols accepted so far, also the write address
  logic [len_w-1:0] step_cnt;
  logic acs_en;
  logic acs_first;
  logic last_acc;
  logic tb_start;
  logic done;
  logic [dist_w-1:0] dist_00;
  logic [dist_w-1:0] dist_01;
  logic [dist_w-1:0] dist_10;
  logic [dist_w-1:0] dist_11;
  decision_t decision;
  decision_t rd_data;
  state_t best_state;
  logic best_valid;
  logic [addr_w-1:0] rd_addr;

  // input open only while idle or receiving
  assign sym_ready = (state_q == st_idle) || (state_q == st_recv);
  assign acs_en = sym_valid & sym_ready;
  assign acs_first = (state_q == st_idle);
  // a full survivor memory closes the frame as well
  assign last_acc = sym_last || (step_cnt == len_w'(max_frame - 1));
  assign tb_start = best_valid && (state_q == st_decode);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= st_idle;
      step_cnt <= '0;
    end else begin
      case (state_q)
        st_idle, st_recv: begin
          if (acs_en) begin
            step_cnt <= step_cnt + 1'b1;
            state_q <= last_acc ? st_decode : st_recv;
          end
        end
        st_decode: begin
          // step_cnt holds the frame length until the last bit leaves
          if (done) begin
            state_q <= st_idle;
            step_cnt <= '0;
          end
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  branch_metric u_bm (
    .sym     (sym),
    .dist_00 (dist_00),
    .dist_01 (dist_01),
    .dist_10 (dist_10),
    .dist_11 (dist_11)
  );

  add_compare_select u_acs (
    .clk        (clk),
    .rst        (rst),
    .acs_en     (acs_en),
    .acs_first  (acs_first),
    .dist_00    (dist_00),
    .dist_01    (dist_01),
    .dist_10    (dist_10),
    .dist_11    (dist_11),
    .last_in    (last_acc),
    .decision   (decision),
    .best_state (best_state),
    .best_valid (best_valid)
  );

  survivor_memory #(
    .max_frame (max_frame)
  ) u_sm (
    .clk      (clk),
    .wr_en    (acs_en),
    .wr_addr  (step_cnt[addr_w-1:0]),
    .decision (decision),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data)
  );

  traceback #(
    .max_frame (max_frame)
  ) u_tb (
    .clk        (clk),
    .rst        (rst),
    .tb_start   (tb_start),
    .best_state (best_state),
    .frame_len  (step_cnt),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data),
    .bit_out    (bit_out),
    .bit_valid  (bit_valid),
    .bit_last   (bit_last),
    .bit_ready  (bit_ready),
    .done       (done)
  );

endmodule

`default_nettype wire

// File: source/traceback.sv
`timescale 1ns/1ns
`default_nettype none

module traceback
  import viterbi_pkg::*;
#(
  parameter int max_frame = 64
) (
  input  wire                               clk,
  input  wire                               rst,
  input  wire                               tb_start,
  input  wire state_t                       best_state,
  input  wire [$clog2(max_frame + 1)-1:0]   frame_len,
  output logic [$clog2(max_frame)-1:0]      rd_addr,
  input  wire decision_t                    rd_data,
  output logic                              bit_out,
  output logic                              bit_valid,
  output logic                              bit_last,
  input  wire                               bit_ready,
  output logic                              done
);

  localparam int addr_w = $clog2(max_frame);
  localparam int len_w = $clog2(max_frame + 1);

  localparam logic [1:0] ph_idle = 2'd0;
  localparam logic [1:0] ph_walk = 2'd1;
  localparam logic [1:0] ph_emit = 2'd2;

  logic [1:0] phase_q;
  // walks down during traceback, up during output
  logic [addr_w-1:0] ptr_q;
  logic [addr_w-1:0] last_idx_q;
  logic [len_w-1:0] len_m1;
  state_t cur_q;
  logic [max_frame-1:0] bit_buf;
  logic fire;

  assign len_m1 = frame_len - 1'b1;
  assign rd_addr = ptr_q;

  // output side, held until the bit transfers
  assign bit_valid = (phase_q == ph_emit);
  assign bit_out = bit_buf[ptr_q];
  assign bit_last = (ptr_q == last_idx_q);
  assign fire = bit_valid & bit_ready;
  assign done = fire & bit_last;

  always_ff @(posedge clk) begin
    if (rst) begin
      phase_q <= ph_idle;
      ptr_q <= '0;
    end else begin
      case (phase_q)
        ph_idle: begin
          if (tb_start) begin
            phase_q <= ph_walk;
            ptr_q <= len_m1[addr_w-1:0];
          end
        end
        ph_walk: begin
          // frame_len cycles, step 0 is the last one
          if (ptr_q == '0) begin
            phase_q <= ph_emit;
          end else begin
            ptr_q <= ptr_q - 1'b1;
          end
        end
        ph_emit: begin
          if (fire) begin
            if (bit_last) begin
              phase_q <= ph_idle;
              ptr_q <= '0;
            end else begin
              ptr_q <= ptr_q + 1'b1;
            end
          end
        end
        default: phase_q <= ph_idle;
      endcase
    end
  end

  // survivor walk, decoded bit is the state's upper bit
  always_ff @(posedge clk) begin
    if (phase_q == ph_idle && tb_start) begin
      cur_q <= best_state;
      last_idx_q <= len_m1[addr_w-1:0];
    end else if (phase_q == ph_walk) begin
      bit_buf[ptr_q] <= cur_q[state_w-1];
      // predecessor is {low bit, stored decision}
      cur_q <= {cur_q[0], rd_data[cur_q]};
    end
  end

endmodule

`default_nettype wire

// File: source/survivor_memory.sv
`timescale 1ns/1ns
`default_nettype none

module survivor_memory
  import viterbi_pkg::*;
#(
  parameter int max_frame = 64
) (
  input  wire                           clk,
  input  wire                           wr_en,
  input  wire [$clog2(max_frame)-1:0]   wr_addr,
  input  wire decision_t                decision,
  input  wire [$clog2(max_frame)-1:0]   rd_addr,
  output decision_t                     rd_data
);

  // one decision word per trellis step
  decision_t mem [max_frame];

  // written on the same edge as the path metric update
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= decision;
    end
  end

  // async read so traceback steps one address per cycle
  assign rd_data = mem[rd_addr];

endmodule

`default_nettype wire

// File: source/add_compare_select.sv
`timescale 1ns/1ns
`default_nettype none

module add_compare_select
  import viterbi_pkg::*;
(
  input  wire              clk,
  input  wire              rst,
  input  wire              acs_en,
  input  wire              acs_first,
  input  wire [dist_w-1:0] dist_00,
  input  wire [dist_w-1:0] dist_01,
  input  wire [dist_w-1:0] dist_10,
  input  wire [dist_w-1:0] dist_11,
  input  wire              last_in,
  output decision_t        decision,
  output state_t           best_state,
  output logic             best_valid
);

  metric_t pm_q [num_states];
  metric_t pm_d [num_states];
  metric_t prior [num_states];
  // distances indexed by code pair
  logic [dist_w-1:0] dist_by_code [4];

  assign dist_by_code[0] = dist_00;
  assign dist_by_code[1] = dist_01;
  assign dist_by_code[2] = dist_10;
  assign dist_by_code[3] = dist_11;

  // first symbol restarts from state 0
  always_comb begin
    for (int s = 0; s < num_states; s++) begin
      if (acs_first) begin
        prior[s] = (s == 0) ? '0 : metric_max;
      end else begin
        prior[s] = pm_q[s];
      end
    end
  end

  // add, compare, select per next state
  always_comb begin
    state_t nxt;
    state_t pred0;
    state_t pred1;
    logic [metric_w:0] sum0;
    logic [metric_w:0] sum1;
    logic [metric_w:0] win;
    for (int n = 0; n < num_states; n++) begin
      nxt = state_t'(n);
      // both predecessors share nxt[0] as upper bit
      pred0 = {nxt[0], 1'b0};
      pred1 = {nxt[0], 1'b1};
      sum0 = {1'b0, prior[pred0]} + (metric_w + 1)'(dist_by_code[branch_code(nxt, 1'b0)]);
      sum1 = {1'b0, prior[pred1]} + (metric_w + 1)'(dist_by_code[branch_code(nxt, 1'b1)]);
      // tie keeps b = 0
      decision[n] = (sum1 < sum0);
      win = decision[n] ? sum1 : sum0;
      // only the unreachable start states can overflow
      pm_d[n] = win[metric_w] ? metric_max : win[metric_w-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (acs_en) begin
      pm_q <= pm_d;
    end
  end

  // one pulse, metrics already hold the final step
  always_ff @(posedge clk) begin
    if (rst) begin
      best_valid <= 1'b0;
    end else begin
      best_valid <= acs_en & last_in;
    end
  end

  // strict less-than so the lowest state wins a tie
  always_comb begin
    metric_t best_m;
    best_m = pm_q[0];
    best_state = '0;
    for (int s = 1; s < num_states; s++) begin
      if (pm_q[s] < best_m) begin
        best_m = pm_q[s];
        best_state = state_t'(s);
      end
    end
  end

endmodule

`default_nettype wire

// File: source/branch_metric.sv
`timescale 1ns/1ns
`default_nettype none

module branch_metric
  import viterbi_pkg::*;
(
  input  wire  [sym_w-1:0]  sym,
  output logic [dist_w-1:0] dist_00,
  output logic [dist_w-1:0] dist_01,
  output logic [dist_w-1:0] dist_10,
  output logic [dist_w-1:0] dist_11
);

  // count of differing bits between received and expected pair
  function automatic logic [dist_w-1:0] hamming(
    input logic [sym_w-1:0] rx,
    input logic [sym_w-1:0] ref_code
  );
    logic [sym_w-1:0] diff;
    logic [dist_w-1:0] cnt;
    diff = rx ^ ref_code;
    cnt = '0;
    for (int i = 0; i < sym_w; i++) begin
      cnt = cnt + dist_w'(diff[i]);
    end
    return cnt;
  endfunction

  // suffix is the expected pair {c0, c1}
  // purely combinational, the ACS samples these on the accept edge
  always_comb begin
    dist_00 = hamming(sym, sym_w'(0));
    dist_01 = hamming(sym, sym_w'(1));
    dist_10 = hamming(sym, sym_w'(2));
    dist_11 = hamming(sym, sym_w'(3));
  end

endmodule

`default_nettype wire

// File: source/viterbi_pkg.sv
`default_nettype none

package viterbi_pkg;

  // rate 1/2, K=3 trellis, generators 7 and 5 octal
  localparam int num_states = 4;
  localparam int state_w = 2;
  localparam int metric_w = 8;
  // hamming distance over 2 code bits, 0..2
  localparam int dist_w = 2;
  localparam int sym_w = 2;

  typedef logic [metric_w-1:0] metric_t;
  typedef logic [state_w-1:0] state_t;
  // one survivor bit per state
  typedef logic [num_states-1:0] decision_t;

  // start value for states the encoder cannot be in yet
  localparam metric_t metric_max = {metric_w{1'b1}};

  // code pair on the branch into nxt from predecessor {nxt[0], b}
  // u is the upper bit of nxt, old s1 is nxt[0], old s0 is b
  function automatic logic [sym_w-1:0] branch_code(input state_t nxt, input logic b);
    logic c0;
    logic c1;
    c0 = nxt[1] ^ nxt[0] ^ b;
    c1 = nxt[1] ^ b;
    return {c0, c1};
  endfunction

endpackage

`default_nettype wire
